// ==== sources.f ====
+incdir+hw
hw/glue_pkg.sv
hw/bus_decode.sv
hw/system_state.sv
hw/read_merge.sv
hw/minimig_glue.sv
bench/tb_clock.sv
bench/tb_minimig_glue.sv

// ==== Makefile ====
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module minimig_glue

sim:
	verilator --binary --timing --assert -f sources.f --top-module tb_minimig_glue \
		-Mdir $(OBJ) -o sim_glue
	./$(OBJ)/sim_glue | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== bench/tb_minimig_glue.sv ====
//------------------------------
// testbench for the chipset glue
// lcg stimulus, reference model
// of decode, merge, reset, irq, led
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "glue_cfg.svh"

module tb_minimig_glue;

	localparam int TEST_CYCLES = 2 * 16 + 2000 + 400;  // resets, random run, directed

	typedef struct packed {
		logic valid;
		logic wr;
		logic chip, slow, kick, cia_a, cia_b, regs, rtc_sel;
		logic [3:0] nib;
		glue_pkg::bank_t bank;
	} dec_t;

	logic clk;
	logic reset, cpu_req, cpu_wr, freeze, sof, user_reset, led_n;
	glue_pkg::cpu_addr_t cpu_addr;
	glue_pkg::mem_cfg_t mem_cfg;
	glue_pkg::word_t chip_rdata, custom_rdata, cpu_rdata;
	glue_pkg::byte_t cia_a_rdata, cia_b_rdata;
	glue_pkg::rtc_word_t rtc;
	glue_pkg::ipl_t ipl_in, cpu_ipl;
	glue_pkg::bank_t bank;
	logic cpu_ack, cpu_reset_n, sys_reset, pwr_led;
	logic sel_chip, sel_slow, sel_kick, sel_cia_a, sel_cia_b, sel_reg, sel_rtc;

	// next values for the request side
	logic n_reset, n_req, n_wr, n_freeze, n_sof, n_user_reset, n_led_n;
	glue_pkg::cpu_addr_t n_addr;
	glue_pkg::mem_cfg_t n_cfg;
	glue_pkg::ipl_t n_ipl;

	// model state
	dec_t pipe[$];            // requests in flight
	logic m_ovl, m_sys, m_ack, led_seen, checks_on;
	glue_pkg::word_t m_rdata;
	glue_pkg::ipl_t m_ipl;
	int m_frames, sof_pulses, lit;
	logic [31:0] lcg_state;
	string phase;

	tb_clock clk_gen (.clk);

	minimig_glue dut0 (
		.clk, .reset, .cpu_req, .cpu_wr, .cpu_addr, .mem_cfg,
		.chip_rdata, .custom_rdata, .cia_a_rdata, .cia_b_rdata, .rtc,
		.ipl_in, .freeze, .sof, .user_reset, .led_n,
		.cpu_rdata, .cpu_ack, .sel_chip, .sel_slow, .sel_kick, .sel_cia_a, .sel_cia_b,
		.sel_reg, .sel_rtc, .bank, .cpu_ipl, .cpu_reset_n, .sys_reset, .pwr_led
	);

	function logic [31:0] rand32();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// biased toward mapped pages
	function glue_pkg::cpu_addr_t pick_addr();
		logic [31:0] r;
		logic [7:0] page;
		r = rand32();
		case (r[31:29])
			3'd0: page = r[7:0];
			3'd1, 3'd2: page = {3'b000, r[4:0]};       // chip ram
			3'd3: page = 8'hC0 + {3'b000, r[4:0]};     // slow ram and upper io
			3'd4: page = `GLUE_CIA_PAGE;
			3'd5: page = `GLUE_RTC_PAGE;
			3'd6: page = `GLUE_REG_PAGE;
			default: page = {5'b11111, r[2:0]};        // rom
		endcase
		return {page, r[22:8]};
	endfunction

	//------------------------------
	// reference model
	//------------------------------
	function dec_t decode_ref(input logic req, input logic wr, input glue_pkg::cpu_addr_t a,
			input glue_pkg::mem_cfg_t cfg, input logic ovl);
		dec_t d;
		int page, chip_pages, slow_end;
		logic low_rom;
		d = '0;
		page = int'(a[23:16]);
		chip_pages = (int'(cfg[1:0]) + 1) * 8;   // 8 pages per 512 KB
		slow_end = int'(`GLUE_SLOW_BASE) + int'(cfg[3:2]) * 8;
		low_rom = ovl && !wr && page < 8;        // rom seen at 0 while overlaid
		d.nib = a[5:2];
		if (!req)
			return d;
		d.valid = 1'b1;
		d.wr = wr;
		d.chip = page < chip_pages && !low_rom;
		d.slow = page >= int'(`GLUE_SLOW_BASE) && page < slow_end;
		d.kick = page >= int'(`GLUE_KICK_BASE) || low_rom;
		d.cia_a = page == int'(`GLUE_CIA_PAGE) && !a[12];
		d.cia_b = page == int'(`GLUE_CIA_PAGE) && !a[13];
		d.regs = page == int'(`GLUE_REG_PAGE);
		d.rtc_sel = page == int'(`GLUE_RTC_PAGE);
		d.bank = d.chip ? glue_pkg::BANK_CHIP : d.slow ? glue_pkg::BANK_SLOW :
			d.kick ? glue_pkg::BANK_KICK : glue_pkg::BANK_NONE;
		return d;
	endfunction

	function glue_pkg::word_t merge_ref(input dec_t d);
		glue_pkg::word_t w;
		w = '0;
		if (!d.valid || d.wr)
			return w;  // writes read back zero
		if (d.chip || d.slow || d.kick)
			w = w | chip_rdata;
		if (d.regs)
			w = w | custom_rdata;
		if (d.cia_a)
			w = w | {8'h00, cia_a_rdata};
		if (d.cia_b)
			w = w | {cia_b_rdata, 8'h00};
		if (d.rtc_sel)
			w = w | {12'h000, 4'(rtc >> (4 * int'(d.nib)))};
		return w;
	endfunction

	// one clock edge with inputs as the dut samples them
	task model_edge();
		dec_t newest, oldest;
		oldest = pipe.pop_front();
		newest = decode_ref(cpu_req, cpu_wr, cpu_addr, mem_cfg, m_ovl);
		m_rdata = merge_ref(oldest);
		led_seen = led_n | reset;
		if (reset) begin
			newest = '0;
			m_ack = 1'b0;
			m_ovl = 1'b1;
			m_sys = 1'b1;
			m_frames = 0;
			m_ipl = '1;
		end else begin
			m_ack = oldest.valid;
			if (oldest.valid && oldest.wr && oldest.cia_a)
				m_ovl = 1'b0;  // first cia-a write drops the rom
			if (user_reset) begin
				m_sys = 1'b1;
				m_frames = 0;
			end else if (sof && m_sys) begin
				m_frames = m_frames + 1;
				m_sys = m_frames < `GLUE_RESET_FRAMES;
			end
			m_ipl = freeze ? '0 : ipl_in;
		end
		pipe.push_back(newest);
	endtask

	task expect_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED %s %s: expected %0h actual %0h", phase, what, exp, act);
			$display("Result: FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task compare_outputs();
		dec_t e;
		e = pipe[$];
		expect_eq("selects", 64'({e.chip, e.slow, e.kick, e.cia_a, e.cia_b, e.regs, e.rtc_sel}),
			64'({sel_chip, sel_slow, sel_kick, sel_cia_a, sel_cia_b, sel_reg, sel_rtc}));
		expect_eq("bank", 64'(e.bank), 64'(bank));
		expect_eq("cpu_ack", 64'(m_ack), 64'(cpu_ack));
		expect_eq("cpu_rdata", 64'(m_rdata), 64'(cpu_rdata));
		expect_eq("sys_reset", 64'(m_sys), 64'(sys_reset));
		expect_eq("cpu_reset_n", 64'(!m_sys), 64'(cpu_reset_n));
		expect_eq("cpu_ipl", 64'(m_ipl), 64'(cpu_ipl));
		if (led_seen)
			expect_eq("pwr_led dark", 64'(1), 64'(pwr_led));
	endtask

	// drive on the rising edge and check at the falling edge
	task run_cycle();
		@(posedge clk);
		model_edge();
		reset <= n_reset;
		cpu_req <= n_req;
		cpu_wr <= n_wr;
		cpu_addr <= n_addr;
		mem_cfg <= n_cfg;
		ipl_in <= n_ipl;
		freeze <= n_freeze;
		sof <= n_sof;
		user_reset <= n_user_reset;
		led_n <= n_led_n;
		chip_rdata <= 16'(rand32());  // fresh source data every cycle
		custom_rdata <= 16'(rand32());
		cia_a_rdata <= 8'(rand32());
		cia_b_rdata <= 8'(rand32());
		rtc <= {rand32(), rand32()};
		@(negedge clk);
		if (checks_on)
			compare_outputs();
	endtask

	task low_read(input glue_pkg::bank_t want);
		n_req = 1'b1;
		n_wr = 1'b0;
		n_addr = {8'h03, 15'h1234};
		run_cycle();
		n_req = 1'b0;
		run_cycle();
		expect_eq("low read bank", 64'(want), 64'(bank));
	endtask

	task random_stimulus();
		logic [31:0] r;
		r = rand32();
		n_req = r[31:30] != 2'b00;
		n_wr = r[29:28] == 2'b00;
		n_addr = pick_addr();
		n_sof = r[27:25] == 3'd0;
		n_freeze = r[24:21] == 4'd0;
		n_ipl = r[20:18];
		n_led_n = r[17];
	endtask

	//------------------------------
	// test sequence
	//------------------------------
	initial begin
		lcg_state = 32'h716b_7e34;
		pipe.push_back('0);
		{m_ovl, m_sys, m_ack, led_seen, checks_on} = 5'b11010;
		m_rdata = '0;
		m_ipl = '1;
		m_frames = 0;
		sof_pulses = 0;
		{n_reset, n_req, n_wr, n_freeze, n_sof, n_user_reset, n_led_n} = 7'b1000001;
		n_addr = '0;
		n_cfg = 4'b1011;  // 2 MB chip, 1 MB slow
		n_ipl = '1;
		reset <= 1'b1;
		{cpu_req, cpu_wr, freeze, sof, user_reset} <= '0;
		led_n <= 1'b1;
		cpu_addr <= '0;
		mem_cfg <= n_cfg;
		ipl_in <= '1;
		{chip_rdata, custom_rdata, cia_a_rdata, cia_b_rdata} <= '0;
		rtc <= '0;

		phase = "reset";
		repeat (2) run_cycle();  // registers known after two edges
		checks_on = 1'b1;
		repeat (13) run_cycle();
		n_reset = 1'b0;

		phase = "overlay";
		low_read(glue_pkg::BANK_KICK);
		n_req = 1'b1;
		n_wr = 1'b1;
		n_addr = {`GLUE_CIA_PAGE, 2'b00, 1'b1, 1'b0, 11'h001};  // a13 high, a12 low
		run_cycle();
		n_req = 1'b0;
		run_cycle();
		low_read(glue_pkg::BANK_CHIP);

		phase = "reset sequence";
		n_user_reset = 1'b1;
		run_cycle();
		n_user_reset = 1'b0;
		n_sof = 1'b1;
		repeat (2) run_cycle();  // partial count then restart
		n_sof = 1'b0;
		n_user_reset = 1'b1;
		run_cycle();
		n_user_reset = 1'b0;
		sof_pulses = 0;
		while (sys_reset) begin
			sof_pulses = sof_pulses + (sof ? 1 : 0);  // sampled at the coming edge
			n_sof = rand32() > 32'hC000_0000;
			run_cycle();
		end
		expect_eq("sof pulses to release", 64'(`GLUE_RESET_FRAMES), 64'(sof_pulses));
		n_sof = 1'b0;

		phase = "interrupt";
		n_ipl = 3'b010;
		n_freeze = 1'b1;
		repeat (2) run_cycle();
		expect_eq("freeze level 7", 64'(0), 64'(cpu_ipl));
		n_freeze = 1'b0;
		repeat (2) run_cycle();
		expect_eq("ipl passed through", 64'(3'b010), 64'(cpu_ipl));

		phase = "led";
		n_led_n = 1'b0;
		run_cycle();
		repeat (2) begin
			lit = 0;
			repeat (64) begin
				run_cycle();
				lit = lit + (pwr_led ? 0 : 1);
			end
			expect_eq("lit cycles of 64", 64'(60), 64'(lit));
			repeat (5) run_cycle();  // shift the window
		end

		phase = "random";
		for (int i = 0; i < 2000; i++) begin
			if (i % 250 == 0)
				n_cfg = 4'(rand32() >> 12);
			random_stimulus();
			run_cycle();
		end

		phase = "overlay after reset";
		{n_req, n_freeze, n_sof} = 3'b000;
		n_led_n = 1'b1;
		n_reset = 1'b1;
		repeat (16) run_cycle();
		n_reset = 1'b0;
		low_read(glue_pkg::BANK_KICK);
		repeat (2) run_cycle();

		$display("Result: PASSED");
		$finish;
	end

	// watchdog at twice the expected run length
	initial begin
		#(2 * TEST_CYCLES * 40);
		$display("watchdog expired before the test sequence finished");
		$display("Result: FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
//------------------------------
// testbench clock source
// free running, 40 ns period
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #20 clk = ~clk;  // half period

endmodule

`default_nettype wire

// ==== hw/minimig_glue.sv ====
//------------------------------
// chipset glue top
// decode, system state, read merge
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module minimig_glue (
	input wire clk,
	input wire reset,
	// cpu request
	input wire cpu_req,
	input wire cpu_wr,
	input wire glue_pkg::cpu_addr_t cpu_addr,
	input wire glue_pkg::mem_cfg_t mem_cfg,
	// read sources
	input wire glue_pkg::word_t chip_rdata,
	input wire glue_pkg::word_t custom_rdata,
	input wire glue_pkg::byte_t cia_a_rdata,
	input wire glue_pkg::byte_t cia_b_rdata,
	input wire glue_pkg::rtc_word_t rtc,
	// system
	input wire glue_pkg::ipl_t ipl_in,
	input wire freeze,
	input wire sof,
	input wire user_reset,
	input wire led_n,
	output glue_pkg::word_t cpu_rdata,
	output logic cpu_ack,
	output logic sel_chip,
	output logic sel_slow,
	output logic sel_kick,
	output logic sel_cia_a,
	output logic sel_cia_b,
	output logic sel_reg,
	output logic sel_rtc,
	output glue_pkg::bank_t bank,
	output glue_pkg::ipl_t cpu_ipl,
	output logic cpu_reset_n,
	output logic sys_reset,
	output logic pwr_led
);

	logic dec_valid, dec_wr;
	logic [3:0] dec_nibble;
	logic ovl;              // back from system state

	bus_decode u_decode (
		.clk, .reset, .cpu_req, .cpu_wr, .cpu_addr, .mem_cfg, .ovl,
		.sel_chip, .sel_slow, .sel_kick, .sel_cia_a, .sel_cia_b, .sel_reg, .sel_rtc,
		.bank, .dec_valid, .dec_wr, .dec_nibble
	);

	system_state u_state (
		.clk, .reset, .dec_valid, .dec_wr, .sel_cia_a, .sof, .user_reset,
		.ipl_in, .freeze, .led_n,
		.ovl, .sys_reset, .cpu_reset_n, .cpu_ipl, .pwr_led
	);

	// data lands 2 cycles after the request
	read_merge u_merge (
		.clk, .reset, .dec_valid, .dec_wr,
		.sel_chip, .sel_slow, .sel_kick, .sel_cia_a, .sel_cia_b, .sel_reg, .sel_rtc,
		.dec_nibble, .chip_rdata, .custom_rdata, .cia_a_rdata, .cia_b_rdata, .rtc,
		.cpu_rdata, .cpu_ack
	);

endmodule

`default_nettype wire

// ==== hw/read_merge.sv ====
//------------------------------
// cpu read data merge
// or of selected sources, rtc nibble,
// registered with the acknowledge
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module read_merge (
	input wire clk,
	input wire reset,
	input wire dec_valid,
	input wire dec_wr,
	input wire sel_chip,
	input wire sel_slow,
	input wire sel_kick,
	input wire sel_cia_a,
	input wire sel_cia_b,
	input wire sel_reg,
	input wire sel_rtc,
	input wire [3:0] dec_nibble,
	input wire glue_pkg::word_t chip_rdata,    // ram side, all banks
	input wire glue_pkg::word_t custom_rdata,
	input wire glue_pkg::byte_t cia_a_rdata,
	input wire glue_pkg::byte_t cia_b_rdata,
	input wire glue_pkg::rtc_word_t rtc,
	output glue_pkg::word_t cpu_rdata,
	output logic cpu_ack
);

	logic rd;                    // decoded read
	logic [3:0] rtc_nib;
	glue_pkg::word_t merged;

	always_comb begin
		rd = dec_valid & ~dec_wr;
		rtc_nib = rtc[{dec_nibble, 2'b00} +: 4];

		merged = '0;
		if (sel_chip | sel_slow | sel_kick)
			merged = merged | chip_rdata;
		if (sel_reg)
			merged = merged | custom_rdata;
		if (sel_cia_a)
			merged = merged | {8'h00, cia_a_rdata};  // low lane
		if (sel_cia_b)
			merged = merged | {cia_b_rdata, 8'h00};  // high lane
		if (sel_rtc)
			merged = merged | {12'h000, rtc_nib};
	end

	// data only on reads
	always_ff @(posedge clk) begin
		cpu_rdata <= rd ? merged : '0;
	end

	// every access gets its ack
	always_ff @(posedge clk) begin
		if (reset)
			cpu_ack <= 1'b0;
		else
			cpu_ack <= dec_valid;
	end

endmodule

`default_nettype wire

// ==== hw/system_state.sv ====
//------------------------------
// system state
// overlay latch, frame counted reset,
// level 7 override, power led dimmer
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "glue_cfg.svh"

module system_state (
	input wire clk,
	input wire reset,
	input wire dec_valid,
	input wire dec_wr,
	input wire sel_cia_a,
	input wire sof,                      // start of frame pulse
	input wire user_reset,               // user or external request
	input wire glue_pkg::ipl_t ipl_in,
	input wire freeze,                   // nmi button
	input wire led_n,                    // cia port led, active low
	output logic ovl,
	output logic sys_reset,
	output logic cpu_reset_n,
	output glue_pkg::ipl_t cpu_ipl,
	output logic pwr_led
);

	typedef logic [`GLUE_RESET_CNT_BITS-1:0] frame_cnt_t;
	typedef enum logic [1:0] {
		RST_HOLD,   // request active or nothing counted yet
		RST_COUNT,  // counting frames
		RST_RUN
	} rst_state_t;

	rst_state_t rst_state;
	frame_cnt_t frame_cnt;
	logic [`GLUE_LED_BITS-1:0] led_cnt;

	// rom overlay, gone on first cia-a write
	always_ff @(posedge clk) begin
		if (reset)
			ovl <= 1'b1;
		else if (dec_valid & dec_wr & sel_cia_a)
			ovl <= 1'b0;
	end

	//------------------------------
	// reset sequencer
	//------------------------------
	always_ff @(posedge clk) begin
		if (reset | user_reset) begin
			rst_state <= RST_HOLD;  // any request restarts the count
			frame_cnt <= '0;
			sys_reset <= 1'b1;
		end else begin
			case (rst_state)
				RST_HOLD, RST_COUNT: begin
					if (sof) begin
						if (frame_cnt == frame_cnt_t'(`GLUE_RESET_FRAMES - 1)) begin
							rst_state <= RST_RUN;
							sys_reset <= 1'b0;  // released after last frame
						end else begin
							rst_state <= RST_COUNT;
							frame_cnt <= frame_cnt + 1'b1;
						end
					end
				end
				default: sys_reset <= 1'b0;  // run, stays released
			endcase
		end
	end

	assign cpu_reset_n = ~sys_reset;

	// level 7 while freeze held
	always_ff @(posedge clk) begin
		if (reset)
			cpu_ipl <= '1;  // no interrupt
		else
			cpu_ipl <= freeze ? '0 : ipl_in;
	end

	//------------------------------
	// power led, off 4 of 64 states
	//------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			led_cnt <= '0;
			pwr_led <= 1'b1;
		end else begin
			led_cnt <= led_cnt + 1'b1;
			pwr_led <= led_n | ~(|led_cnt[`GLUE_LED_BITS-1:2]);  // low = lit
		end
	end

endmodule

`default_nettype wire

// ==== hw/bus_decode.sv ====
//------------------------------
// cpu address decoder
// one register stage of selects,
// bank code and request flags
//------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "glue_cfg.svh"

module bus_decode (
	input wire clk,
	input wire reset,
	input wire cpu_req,                      // one cycle per access
	input wire cpu_wr,
	input wire glue_pkg::cpu_addr_t cpu_addr,
	input wire glue_pkg::mem_cfg_t mem_cfg,
	input wire ovl,                          // kickstart overlay
	output logic sel_chip,
	output logic sel_slow,
	output logic sel_kick,
	output logic sel_cia_a,
	output logic sel_cia_b,
	output logic sel_reg,
	output logic sel_rtc,
	output glue_pkg::bank_t bank,
	output logic dec_valid,
	output logic dec_wr,
	output logic [3:0] dec_nibble            // address bits 5..2
);

	logic [7:0] page;       // 64 KB page
	logic [7:0] chip_top;   // first page above chip ram
	logic [7:0] slow_top;   // first page above slow ram
	logic ovl_rd;           // overlay read of low 512 KB
	logic hit_cia;
	logic nxt_chip, nxt_slow, nxt_kick;
	glue_pkg::bank_t nxt_bank;

	//------------------------------
	// address map
	//------------------------------
	always_comb begin
		page = cpu_addr[23:16];
		chip_top = 8'((mem_cfg[1:0] + 3'd1) * `GLUE_CHIP_LIMIT_STEP);
		slow_top = 8'(`GLUE_SLOW_BASE + mem_cfg[3:2] * `GLUE_SLOW_STEP);
		ovl_rd = ovl & ~cpu_wr & (page < 8'(`GLUE_CHIP_LIMIT_STEP));
		hit_cia = (page == `GLUE_CIA_PAGE);

		// chip limited by size, never past 2 MB
		nxt_chip = (page < chip_top) & (page < `GLUE_CHIP_LIMIT_TOP) & ~ovl_rd;
		nxt_slow = (page >= `GLUE_SLOW_BASE) & (page < slow_top);  // empty for size 0
		nxt_kick = (page >= `GLUE_KICK_BASE) | ovl_rd;  // rom mirrored low while ovl

		if (nxt_chip)
			nxt_bank = glue_pkg::BANK_CHIP;
		else if (nxt_slow)
			nxt_bank = glue_pkg::BANK_SLOW;
		else if (nxt_kick)
			nxt_bank = glue_pkg::BANK_KICK;
		else
			nxt_bank = glue_pkg::BANK_NONE;  // io pages and holes
	end

	//------------------------------
	// request stage
	//------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			sel_chip <= 1'b0;
			sel_slow <= 1'b0;
			sel_kick <= 1'b0;
			sel_cia_a <= 1'b0;
			sel_cia_b <= 1'b0;
			sel_reg <= 1'b0;
			sel_rtc <= 1'b0;
			bank <= glue_pkg::BANK_NONE;
			dec_valid <= 1'b0;
			dec_wr <= 1'b0;
		end else begin
			sel_chip <= cpu_req & nxt_chip;
			sel_slow <= cpu_req & nxt_slow;
			sel_kick <= cpu_req & nxt_kick;
			sel_cia_a <= cpu_req & hit_cia & ~cpu_addr[12];  // a12 low, odd byte cia
			sel_cia_b <= cpu_req & hit_cia & ~cpu_addr[13];  // a13 low, even byte cia
			sel_reg <= cpu_req & (page == `GLUE_REG_PAGE);
			sel_rtc <= cpu_req & (page == `GLUE_RTC_PAGE);
			bank <= cpu_req ? nxt_bank : glue_pkg::BANK_NONE;
			dec_valid <= cpu_req;
			dec_wr <= cpu_req & cpu_wr;
		end
		dec_nibble <= cpu_addr[5:2];  // rtc register index
	end

endmodule

`default_nettype wire

// ==== hw/glue_pkg.sv ====
//------------------------------
// glue package
// shared vector types, bank codes
//------------------------------
`default_nettype none

package glue_pkg;

	// cpu word address, bits 23..1 of the byte address
	typedef logic [23:1] cpu_addr_t;

	typedef logic [15:0] word_t;      // cpu data word
	typedef logic [7:0] byte_t;       // cia data port

	// [1:0] chip size, 512K..2M
	// [3:2] slow size, 0..1.5M
	typedef logic [3:0] mem_cfg_t;

	typedef logic [63:0] rtc_word_t;  // 16 bcd nibbles from the clock chip

	typedef logic [2:0] ipl_t;        // active low interrupt level

	// memory bank seen by the ram side
	typedef enum logic [1:0] {
		BANK_NONE,
		BANK_CHIP,
		BANK_SLOW,
		BANK_KICK
	} bank_t;

endpackage

`default_nettype wire

// ==== hw/glue_cfg.svh ====
//------------------------------
// glue configuration
// address map in 64 KB pages, reset
// frame count, counter widths
//------------------------------
`ifndef GLUE_CFG_SVH
`define GLUE_CFG_SVH

// chip ram grows in 512 KB steps from page 0
`define GLUE_CHIP_LIMIT_STEP 8        // pages per 512 KB
`define GLUE_CHIP_LIMIT_TOP 8'h20     // end of chip window, 2 MB

// slow ram at $C00000, 0 to 1.5 MB
`define GLUE_SLOW_BASE 8'hC0
`define GLUE_SLOW_STEP 8

// io pages
`define GLUE_CIA_PAGE 8'hBF           // both cias
`define GLUE_RTC_PAGE 8'hDC           // clock chip
`define GLUE_REG_PAGE 8'hDF           // custom registers
`define GLUE_KICK_BASE 8'hF8          // 512 KB kickstart rom

// reset sequencer
`define GLUE_RESET_FRAMES 4
`define GLUE_RESET_CNT_BITS 3

`define GLUE_LED_BITS 6               // power led pwm counter

`endif
